/* common/n163_pkg.sv */
// n163 mapper shared constants, address window codes and bank byte type
package n163_pkg;

	localparam int PRG_BANK_W  = 6;
	localparam int CHR_BANK_W  = 8;
	localparam int WAVE_ADDR_W = 7;
	localparam int N_CHR_BANKS = 12; // 8 pattern + 4 nametable

	localparam logic [PRG_BANK_W-1:0] PRG_FIXED_BANK = '1; // E000-FFFF
	localparam logic [8:0]            WRAM_REGION    = 9'h3c0;
	localparam logic [3:0]            CHR_REGION     = 4'h8;

	// cpu address bits 15:11
	localparam logic [4:0] WIN_SOUND_DATA = 5'b01001; // 4800
	localparam logic [4:0] WIN_IRQ_LO     = 5'b01010; // 5000
	localparam logic [4:0] WIN_IRQ_HI     = 5'b01011; // 5800
	localparam logic [4:0] WIN_SOUND_PTR  = 5'b11111; // F800
	localparam logic [4:0] WIN_CHR_FIRST  = 5'b10000; // 8000
	localparam logic [4:0] WIN_PRG89      = 5'b11100; // E000
	localparam logic [4:0] WIN_PRGAB      = 5'b11101; // E800
	localparam logic [4:0] WIN_PRGCD      = 5'b11110; // F000

	// one bank byte, read as a rom page or as a console vram select
	typedef union packed {
		logic [CHR_BANK_W-1:0] rom_page;
		struct packed {
			logic [2:0] marker; // all ones selects ciram
			logic [3:0] unused;
			logic       a10;
		} ciram;
	} chr_bank_t;

endpackage

/* n163/n163_bank_regs.sv */
// n163 bank registers, written by cpu stores at 8000-F7FF
`timescale 1ns/1ps

module n163_bank_regs import n163_pkg::*; (
	input  logic                  clk20,
	input  logic                  reset,
	input  logic                  cpu_ce,
	input  logic                  prg_we,
	input  logic [15:0]           prg_addr,
	input  logic [7:0]            prg_din,
	output chr_bank_t             chr_bank [N_CHR_BANKS],
	output logic [PRG_BANK_W-1:0] prg89,
	output logic [PRG_BANK_W-1:0] prgab,
	output logic [PRG_BANK_W-1:0] prgcd,
	output logic [1:0]            chr_ram_en
);

	logic [4:0] win;
	logic       wr;
	logic       chr_hit;

	assign win = prg_addr[15:11];
	assign wr  = cpu_ce & prg_we;
	assign chr_hit = (win >= WIN_CHR_FIRST) && (win < WIN_PRG89); // 8000-DFFF

	always_ff @(posedge clk20) begin
		if (reset) begin
			for (int i = 0; i < N_CHR_BANKS; i++) begin
				chr_bank[i] <= '0;
			end
			prg89      <= '0;
			prgab      <= '0;
			prgcd      <= '0;
			chr_ram_en <= '0;
		end else if (wr) begin
			if (chr_hit) begin
				chr_bank[win[3:0]] <= chr_bank_t'(prg_din); // slot order follows address
			end
			case (win)
				WIN_PRG89: prg89 <= prg_din[PRG_BANK_W-1:0]; // 7:6 ignored
				WIN_PRGAB: begin
					chr_ram_en <= prg_din[7:6];
					prgab      <= prg_din[PRG_BANK_W-1:0];
				end
				WIN_PRGCD: prgcd <= prg_din[PRG_BANK_W-1:0];
				default: ;
			endcase
		end
	end

endmodule

/* n163/n163_prg_map.sv */
// n163 program address translation with access allow and data bus drive
`timescale 1ns/1ps

module n163_prg_map import n163_pkg::*; (
	input  logic [15:0]           prg_addr,
	input  logic                  prg_we,
	input  logic [PRG_BANK_W-1:0] prg89,
	input  logic [PRG_BANK_W-1:0] prgab,
	input  logic [PRG_BANK_W-1:0] prgcd,
	output logic [21:0]           prg_aout,
	output logic                  prg_allow,
	output logic                  prg_drive
);

	logic [PRG_BANK_W-1:0] bank;
	logic                  is_wram;
	logic                  is_regs;
	logic [4:0]            win;

	assign win     = prg_addr[15:11];
	assign is_wram = prg_addr[15:13] == 3'b011; // 6000-7FFF
	assign is_regs = (win == WIN_SOUND_DATA) || (win == WIN_IRQ_LO) || (win == WIN_IRQ_HI);

	always_comb begin
		case (prg_addr[14:13])
			2'd0:    bank = prg89;
			2'd1:    bank = prgab;
			2'd2:    bank = prgcd;
			default: bank = PRG_FIXED_BANK;
		endcase
	end

	assign prg_aout = is_wram ? {WRAM_REGION, prg_addr[12:0]}
		: {3'b000, bank, prg_addr[12:0]};

	assign prg_allow = is_wram | (prg_addr[15] & ~prg_we);
	assign prg_drive = ~prg_we & (is_wram | prg_addr[15] | is_regs);

endmodule

/* n163/n163_chr_map.sv */
// n163 pattern and nametable bank select with ciram routing
`timescale 1ns/1ps

module n163_chr_map import n163_pkg::*; (
	input  logic [13:0] chr_addr,
	input  logic        chr_rd,
	input  logic        chr_wr,
	input  chr_bank_t   chr_bank [N_CHR_BANKS],
	input  logic [1:0]  chr_ram_en,
	output logic [21:0] chr_aout,
	output logic        chr_allow,
	output logic        vram_ce,
	output logic        vram_a10
);

	logic [3:0] idx;
	chr_bank_t  bank;
	logic       marker_set;
	logic       en_bit;
	logic       ram_cond;

	// slots 8-15 fold onto the four nametable banks
	assign idx = chr_addr[13] ? {2'b10, chr_addr[11:10]} : {1'b0, chr_addr[12:10]};
	assign bank = chr_bank[idx];

	assign marker_set = &bank.ciram.marker;
	assign en_bit     = chr_addr[12] ? chr_ram_en[1] : chr_ram_en[0];
	assign ram_cond   = marker_set & ~en_bit;

	always_comb begin
		if (!chr_addr[13]) begin
			vram_ce   = ram_cond;
			chr_allow = chr_wr & ram_cond;
		end else begin
			vram_ce   = marker_set;
			chr_allow = chr_wr & ram_cond & ~marker_set;
		end
	end

	assign chr_aout = {CHR_REGION, bank.rom_page, chr_addr[9:0]};
	assign vram_a10 = bank.ciram.a10;

endmodule

/* hw/n163_irq_counter.sv */
// n163 15-bit up-counting irq timer with cpu load and readback
`timescale 1ns/1ps

module n163_irq_counter import n163_pkg::*; (
	input  logic        clk20,
	input  logic        reset,
	input  logic        cpu_ce,
	input  logic        prg_we,
	input  logic [15:0] prg_addr,
	input  logic [7:0]  prg_din,
	output logic [15:0] count,
	output logic        irq
);

	logic [4:0]  win;
	logic [15:0] count_next;
	logic        countup;
	logic        ack;
	logic        load_lo;
	logic        load_hi;

	assign win        = prg_addr[15:11];
	assign count_next = count + 16'd1;
	assign countup    = count[15] & ~&count[14:0]; // stops at FFFF
	assign ack        = (win == WIN_IRQ_LO) || (win == WIN_IRQ_HI);
	assign load_lo    = prg_we & (win == WIN_IRQ_LO);
	assign load_hi    = prg_we & (win == WIN_IRQ_HI);

	always_ff @(posedge clk20) begin
		if (reset) begin
			irq <= 1'b0;
		end else if (cpu_ce) begin
			if (ack) begin
				irq <= 1'b0; // any 5000-5FFF access acknowledges
			end else if (count == 16'hffff) begin
				irq <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			count <= '0;
		end else if (cpu_ce) begin
			if (load_lo)
				count[7:0] <= prg_din;
			else if (countup)
				count[7:0] <= count_next[7:0];

			if (load_hi)
				count[15:8] <= prg_din;
			else if (countup)
				count[15:8] <= count_next[15:8];
		end
	end

endmodule

/* hw/n163_wave_ram.sv */
// n163 128-byte sound ram behind the 4800 data port and F800 pointer
`timescale 1ns/1ps

module n163_wave_ram import n163_pkg::*; (
	input  logic        clk20,
	input  logic        reset,
	input  logic        cpu_ce,
	input  logic        prg_we,
	input  logic [15:0] prg_addr,
	input  logic [7:0]  prg_din,
	output logic [7:0]  wave_q
);

	logic [7:0]             mem [2**WAVE_ADDR_W];
	logic [WAVE_ADDR_W-1:0] ptr;
	logic                   autoinc;
	logic                   data_acc;
	logic                   ptr_wr;

	assign data_acc = cpu_ce & (prg_addr[15:11] == WIN_SOUND_DATA);
	assign ptr_wr   = cpu_ce & prg_we & (prg_addr[15:11] == WIN_SOUND_PTR);

	always_ff @(posedge clk20) begin
		if (reset) begin
			ptr     <= '0;
			autoinc <= 1'b0;
		end else if (ptr_wr) begin
			{autoinc, ptr} <= prg_din;
		end else if (data_acc && autoinc) begin
			ptr <= ptr + 1'b1; // reads and writes both step
		end
	end

	always_ff @(posedge clk20) begin
		if (data_acc && prg_we)
			mem[ptr] <= prg_din;
		wave_q <= mem[ptr];
	end

endmodule

/* hw/n163_mapper.sv */
// n163 mapper top level, bank, timer and sound ram blocks with cpu read mux
`timescale 1ns/1ps

module n163_mapper import n163_pkg::*; (
	input  logic        clk20,
	input  logic        reset,
	input  logic        cpu_ce,
	input  logic [15:0] prg_addr,
	input  logic        prg_we,
	input  logic [7:0]  prg_din,
	input  logic [13:0] chr_addr,
	input  logic        chr_rd,
	input  logic        chr_wr,
	output logic [21:0] prg_aout,
	output logic        prg_allow,
	output logic        prg_drive,
	output logic [7:0]  prg_dout,
	output logic [21:0] chr_aout,
	output logic        chr_allow,
	output logic        vram_ce,
	output logic        vram_a10,
	output logic        irq
);

	chr_bank_t             chr_bank [N_CHR_BANKS];
	logic [PRG_BANK_W-1:0] prg89;
	logic [PRG_BANK_W-1:0] prgab;
	logic [PRG_BANK_W-1:0] prgcd;
	logic [1:0]            chr_ram_en;
	logic [15:0]           count;
	logic [7:0]            wave_q;

	n163_bank_regs n163_bank_regs_inst (
		.clk20      (clk20),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.prg_we     (prg_we),
		.prg_addr   (prg_addr),
		.prg_din    (prg_din),
		.chr_bank   (chr_bank),
		.prg89      (prg89),
		.prgab      (prgab),
		.prgcd      (prgcd),
		.chr_ram_en (chr_ram_en)
	);

	n163_prg_map n163_prg_map_inst (
		.prg_addr  (prg_addr),
		.prg_we    (prg_we),
		.prg89     (prg89),
		.prgab     (prgab),
		.prgcd     (prgcd),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.prg_drive (prg_drive)
	);

	n163_chr_map n163_chr_map_inst (
		.chr_addr   (chr_addr),
		.chr_rd     (chr_rd),
		.chr_wr     (chr_wr),
		.chr_bank   (chr_bank),
		.chr_ram_en (chr_ram_en),
		.chr_aout   (chr_aout),
		.chr_allow  (chr_allow),
		.vram_ce    (vram_ce),
		.vram_a10   (vram_a10)
	);

	n163_irq_counter n163_irq_counter_inst (
		.clk20    (clk20),
		.reset    (reset),
		.cpu_ce   (cpu_ce),
		.prg_we   (prg_we),
		.prg_addr (prg_addr),
		.prg_din  (prg_din),
		.count    (count),
		.irq      (irq)
	);

	n163_wave_ram n163_wave_ram_inst (
		.clk20    (clk20),
		.reset    (reset),
		.cpu_ce   (cpu_ce),
		.prg_we   (prg_we),
		.prg_addr (prg_addr),
		.prg_din  (prg_din),
		.wave_q   (wave_q)
	);

	// mapper readback, open bus passes cpu data through
	always_comb begin
		case (prg_addr[15:11])
			WIN_SOUND_DATA: prg_dout = wave_q;
			WIN_IRQ_LO:     prg_dout = count[7:0];
			WIN_IRQ_HI:     prg_dout = count[15:8];
			default:        prg_dout = prg_din;
		endcase
	end

endmodule

/* test/n163_clk_gen.sv */
// testbench clock and reset source, 4 ns period with two reset cycles
`timescale 1ns/1ps

module n163_clk_gen (
	output logic clk20,
	output logic reset
);

	initial begin
		clk20 = 1'b0;
		forever #2 clk20 = ~clk20;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk20);
		reset <= 1'b0; // released on the second rising edge
	end

endmodule

/* test/n163_irq_props.sv */
// irq timer assertions, bound into the n163 interrupt counter
`timescale 1ns/1ps

module n163_irq_props (
	input logic        clk20,
	input logic        reset,
	input logic        cpu_ce,
	input logic [15:0] prg_addr,
	input logic [15:0] count,
	input logic        irq
);

	int   assert_fails = 0;
	logic ack_access;

	assign ack_access = cpu_ce && (prg_addr[15:12] == 4'h5); // 5000-5FFF

	irq_rise: assert property (@(posedge clk20) disable iff (reset)
		$rose(irq) |-> $past(cpu_ce && count == 16'hffff))
		else begin
			assert_fails++;
			$error("irq rose without count at ffff on a cpu_ce");
		end

	irq_fall: assert property (@(posedge clk20) disable iff (reset)
		$fell(irq) |-> $past(ack_access))
		else begin
			assert_fails++;
			$error("irq fell without an access to 5000-5fff");
		end

	count_hold: assert property (@(posedge clk20) disable iff (reset)
		!$stable(count) |-> $past(cpu_ce))
		else begin
			assert_fails++;
			$error("count changed outside a cpu_ce cycle");
		end

endmodule

bind n163_irq_counter n163_irq_props n163_irq_props_inst (
	.clk20    (clk20),
	.reset    (reset),
	.cpu_ce   (cpu_ce),
	.prg_addr (prg_addr),
	.count    (count),
	.irq      (irq)
);

/* test/n163_tb.sv */
// n163 mapper testbench, random cpu and ppu traffic against a reference model
`timescale 1ns/1ps

module n163_tb import n163_pkg::*; ();

	logic        clk20, reset, cpu_ce, prg_we, chr_rd, chr_wr;
	logic [15:0] prg_addr;
	logic [7:0]  prg_din, prg_dout;
	logic [13:0] chr_addr;
	logic [21:0] prg_aout, chr_aout;
	logic        prg_allow, prg_drive, chr_allow, vram_ce, vram_a10, irq;

	// reference model state
	logic [7:0]  m_chr [N_CHR_BANKS];
	logic [5:0]  m_prg89, m_prgab, m_prgcd;
	logic [1:0]  m_ram_en;
	logic [15:0] m_count;
	logic        m_irq;
	logic [7:0]  m_ram [128];
	logic [6:0]  m_ptr;
	logic        m_inc;

	logic [31:0] lfsr;
	int          errors, errs_at_start, tests, failed_tests;

	n163_clk_gen n163_clk_gen_inst (.clk20(clk20), .reset(reset));

	n163_mapper n163_mapper_inst (.*);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic log_error(input string msg);
		errors++;
		$display("ERR t=%0t %s", $time, msg);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors != errs_at_start)
			failed_tests++;
		$display("%-24s %0d errors", name, errors - errs_at_start);
		errs_at_start = errors;
	endtask

	// one cpu_ce edge of the model, all reads of state before the edge
	task automatic model_access(input logic [15:0] addr, input logic we, input logic [7:0] din);
		logic [4:0]  w;
		logic [15:0] nxt;
		w   = addr[15:11];
		nxt = (m_count[15] && m_count[14:0] != 15'h7fff) ? m_count + 16'd1 : m_count;
		if (addr[15:12] == 4'h5)
			m_irq = 1'b0;
		else if (m_count == 16'hffff)
			m_irq = 1'b1;
		if (we && w == WIN_IRQ_LO)
			nxt[7:0] = din;
		if (we && w == WIN_IRQ_HI)
			nxt[15:8] = din;
		m_count = nxt;
		if (we) begin
			case (w)
				WIN_PRG89: m_prg89 = din[5:0];
				WIN_PRGAB: begin
					m_ram_en = din[7:6];
					m_prgab  = din[5:0];
				end
				WIN_PRGCD:     m_prgcd = din[5:0];
				WIN_SOUND_PTR: {m_inc, m_ptr} = din;
				default: begin
					if (w >= WIN_CHR_FIRST && w < WIN_PRG89)
						m_chr[w - WIN_CHR_FIRST] = din;
				end
			endcase
		end
		if (w == WIN_SOUND_DATA) begin
			if (we)
				m_ram[m_ptr] = din;
			if (m_inc)
				m_ptr = m_ptr + 7'd1;
		end
	endtask

	// one cpu access, cpu_ce high for a cycle then two idle cycles
	task automatic bus_cycle(input logic [15:0] addr, input logic we, input logic [7:0] din,
			output logic [7:0] dout);
		@(negedge clk20);
		prg_addr = addr;
		prg_we   = we;
		prg_din  = din;
		cpu_ce   = 1'b1;
		#1;
		dout = prg_dout;
		model_access(addr, we, din);
		@(negedge clk20);
		cpu_ce = 1'b0;
		prg_we = 1'b0;
		@(negedge clk20);
		if (irq !== m_irq)
			log_error($sformatf("irq %b expected %b after access to %h", irq, m_irq, addr));
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] din);
		logic [7:0] unused_q;
		bus_cycle(addr, 1'b1, din, unused_q);
	endtask

	initial begin
		logic [7:0]  d;
		logic [7:0]  exp;
		logic [7:0]  bank;
		logic [5:0]  pbank;
		logic [3:0]  slot;
		logic [6:0]  start;
		logic [21:0] exp_aout;
		logic        marker, ram_ok, exp_allow, wram, regs;
		int          n;

		cpu_ce   = 1'b0;
		prg_we   = 1'b0;
		prg_addr = '0;
		prg_din  = '0;
		chr_addr = '0;
		chr_rd   = 1'b0;
		chr_wr   = 1'b0;
		lfsr     = 32'hc780_d1c4;
		for (int i = 0; i < N_CHR_BANKS; i++)
			m_chr[i] = '0;
		{m_prg89, m_prgab, m_prgcd, m_ram_en} = '0;
		{m_count, m_irq, m_ptr, m_inc} = '0;
		errors = 0;
		errs_at_start = 0;
		tests = 0;
		failed_tests = 0;

		n = 0;
		while (reset !== 1'b0 && n < 20) begin
			@(negedge clk20);
			n++;
		end
		if (reset !== 1'b0)
			report_problem("reset was never released");

		// state right after reset
		if (irq !== 1'b0)
			log_error("irq high after reset");
		bus_cycle(16'h5000, 1'b0, 8'h00, d);
		if (d !== 8'h00)
			log_error($sformatf("5000 read %h after reset", d));
		finish_test("reset state");

		for (int i = 0; i < 48; i++) begin
			exp = rand_bits(1) ? {3'b111, 5'(rand_bits(5))} : 8'(rand_bits(8)); // bias to ciram
			cpu_write({5'd16 + 5'(rand_bits(4) % 15), 11'(rand_bits(11))}, exp);
		end
		for (int i = 0; i < 200; i++) begin
			@(negedge clk20);
			chr_addr = 14'(rand_bits(14));
			chr_wr   = 1'(rand_bits(1));
			chr_rd   = 1'(rand_bits(1));
			#1;
			slot      = chr_addr[13:10];
			bank      = slot[3] ? m_chr[8 + slot[1:0]] : m_chr[slot];
			marker    = &bank[7:5];
			ram_ok    = marker & ~m_ram_en[chr_addr[12]];
			exp_allow = chr_wr & ram_ok & (slot[3] ? ~marker : 1'b1);
			if (chr_aout !== {CHR_REGION, bank, chr_addr[9:0]})
				log_error($sformatf("chr_aout %h at chr %h", chr_aout, chr_addr));
			if (vram_ce !== (slot[3] ? marker : ram_ok))
				log_error($sformatf("vram_ce %b at chr %h", vram_ce, chr_addr));
			if (vram_a10 !== bank[0])
				log_error($sformatf("vram_a10 %b at chr %h", vram_a10, chr_addr));
			if (chr_allow !== exp_allow)
				log_error($sformatf("chr_allow %b at chr %h", chr_allow, chr_addr));
		end
		chr_rd = 1'b0;
		chr_wr = 1'b0;
		finish_test("chr banks");

		for (int i = 0; i < 6; i++)
			cpu_write({5'd28 + 5'(rand_bits(2) % 3), 11'(rand_bits(11))}, 8'(rand_bits(8)));
		for (int i = 0; i < 200; i++) begin
			@(negedge clk20);
			prg_addr = 16'(rand_bits(16));
			prg_we   = 1'(rand_bits(1));
			#1;
			wram  = prg_addr[15:13] == 3'b011;
			regs  = prg_addr >= 16'h4800 && prg_addr < 16'h6000;
			pbank = prg_addr[14] ? (prg_addr[13] ? PRG_FIXED_BANK : m_prgcd)
				: (prg_addr[13] ? m_prgab : m_prg89);
			exp_aout = wram ? {WRAM_REGION, prg_addr[12:0]} : {3'b000, pbank, prg_addr[12:0]};
			if ((wram || prg_addr[15]) && prg_aout !== exp_aout)
				log_error($sformatf("prg_aout %h expected %h at %h", prg_aout, exp_aout, prg_addr));
			if (prg_allow !== (wram | (prg_addr[15] & ~prg_we)))
				log_error($sformatf("prg_allow %b at %h we %b", prg_allow, prg_addr, prg_we));
			if (prg_drive !== (~prg_we & (wram | prg_addr[15] | regs)))
				log_error($sformatf("prg_drive %b at %h we %b", prg_drive, prg_addr, prg_we));
		end
		prg_we = 1'b0;
		finish_test("prg mapping");

		cpu_write(16'h5800, 8'hff);
		cpu_write(16'h5000, 8'hf0 | 8'(rand_bits(4)));
		n = 0;
		while (irq !== 1'b1 && n < 64) begin
			bus_cycle(16'h0100, 1'b0, 8'h00, d); // steps the counter only
			n++;
		end
		if (irq !== 1'b1)
			report_problem("timed out waiting for irq to rise");
		else if (m_count !== 16'hffff)
			log_error($sformatf("irq high with model count %h", m_count));
		exp = m_count[7:0];
		bus_cycle(16'h5000, 1'b0, 8'h00, d);
		if (d !== exp)
			log_error($sformatf("5000 read %h expected %h", d, exp));
		exp = m_count[15:8];
		bus_cycle(16'h5800, 1'b0, 8'h00, d);
		if (d !== exp)
			log_error($sformatf("5800 read %h expected %h", d, exp));
		finish_test("irq counter");

		bus_cycle(16'h0100, 1'b0, 8'h00, d); // count still ffff, irq comes back
		bus_cycle({4'h5, 12'(rand_bits(12))}, 1'b0, 8'h00, d);
		n = 0;
		while (irq !== 1'b0 && n < 8) begin
			@(negedge clk20);
			n++;
		end
		if (irq !== 1'b0)
			report_problem("timed out waiting for irq to clear after a 5000-5fff access");
		cpu_write(16'h5800, 8'h00);
		cpu_write(16'h5000, 8'h00);
		finish_test("irq acknowledge");

		start = 7'(rand_bits(7));
		cpu_write(16'hf800 | 16'(rand_bits(11)), {1'b1, start});
		for (int i = 0; i < 24; i++)
			cpu_write(16'h4800 | 16'(rand_bits(11)), 8'(rand_bits(8)));
		cpu_write(16'hf800 | 16'(rand_bits(11)), {1'b1, start});
		for (int i = 0; i < 24; i++) begin
			exp = m_ram[m_ptr];
			bus_cycle(16'h4800 | 16'(rand_bits(11)), 1'b0, 8'h00, d);
			if (d !== exp)
				log_error($sformatf("sound ram read %h expected %h", d, exp));
		end
		finish_test("sound ram");

		n = n163_mapper_inst.n163_irq_counter_inst.n163_irq_props_inst.assert_fails;
		if (n != 0)
			report_problem($sformatf("%0d irq timer assertions failed", n));
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* sources.f */
common/n163_pkg.sv
n163/n163_bank_regs.sv
n163/n163_prg_map.sv
n163/n163_chr_map.sv
hw/n163_irq_counter.sv
hw/n163_wave_ram.sv
hw/n163_mapper.sv
test/n163_clk_gen.sv
test/n163_irq_props.sv
test/n163_tb.sv

/* Bender.yml */
package:
  name: n163_mapper

sources:
  - files:
      - common/n163_pkg.sv
      - n163/n163_bank_regs.sv
      - n163/n163_prg_map.sv
      - n163/n163_chr_map.sv
      - hw/n163_irq_counter.sv
      - hw/n163_wave_ram.sv
      - hw/n163_mapper.sv
  - target: test
    files:
      - test/n163_clk_gen.sv
      - test/n163_irq_props.sv
      - test/n163_tb.sv
